// File: icache.f
+incdir+.
icache_pkg.sv
icache_fill_if.sv
icache_lookup.sv
icache_memctrl.sv
icache_top.sv
icache_tb_clk.sv
icache_tb_mem.sv
icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= icache_tb
FILELIST  ?= icache.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: icache_tb.sv
/* Instruction cache testbench */

`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

    localparam logic [31:0] seed_value  = 32'h06fd_4ab4;
    localparam logic [31:0] pattern_key = 32'h5a5a_0000;
    // About 400 worst-case misses plus the flushes
    localparam int          cycle_limit = 20000;

    logic        aclk;
    logic        rst;
    logic        flush_req;
    logic        flush_ack;
    logic        ctrl_arvalid;
    logic        ctrl_arready;
    addr_t       ctrl_araddr;
    logic        ctrl_rvalid;
    logic        ctrl_rready;
    word_t       ctrl_rdata;
    logic        mem_arvalid;
    logic        mem_arready;
    addr_t       mem_araddr;
    logic [7:0]  mem_arlen;
    logic [2:0]  mem_arsize;
    logic [1:0]  mem_arburst;
    logic        mem_rvalid;
    logic        mem_rready;
    line_t       mem_rdata;
    logic [1:0]  mem_rresp;
    logic        mem_rlast;

    integer      seed = seed_value;
    logic [31:0] rnd;
    int          cycles = 0;
    int          mismatch_errs = 0;
    int          protocol_errs = 0;
    // Reference model of which lines are held
    logic [15:0] model_valid;
    tag_t        model_tag [16];
    index_t      acc_index;
    tag_t        acc_tag;
    addr_t       exp_addr;
    logic        exp_miss;
    word_t       exp_word;
    logic        busy;
    int          ar_count;

    icache_tb_clk clk_gen_i (
        .aclk (aclk)
    );

    icache_tb_mem #(
        .seed_init   (seed_value),
        .pattern_key (pattern_key)
    ) mem_i (
        .aclk    (aclk),
        .rst     (rst),
        .arvalid (mem_arvalid),
        .arready (mem_arready),
        .araddr  (mem_araddr),
        .rvalid  (mem_rvalid),
        .rready  (mem_rready),
        .rdata   (mem_rdata),
        .rresp   (mem_rresp),
        .rlast   (mem_rlast)
    );

    icache_top icache_top_i (.*);

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Tag in bits 15:8, index in 7:4
    assign acc_index = ctrl_araddr[7:4];
    assign acc_tag   = ctrl_araddr[15:8];
    assign exp_word  = {16'h0, exp_addr[15:2], 2'b00} ^ pattern_key;

    always @(posedge aclk) begin
        if (rst) begin
            model_valid <= '0;
            busy        <= 1'b0;
            ar_count    <= 0;
        end else begin
            if (ctrl_arvalid && ctrl_arready) begin
                exp_addr               <= ctrl_araddr;
                exp_miss               <= !(model_valid[acc_index] &&
                                            model_tag[acc_index] == acc_tag);
                model_valid[acc_index] <= 1'b1;
                model_tag[acc_index]   <= acc_tag;
                busy                   <= 1'b1;
                ar_count               <= 0;
            end
            if (mem_arvalid && mem_arready) begin
                ar_count <= ar_count + 1;
            end
            if (ctrl_rvalid && ctrl_rready) begin
                busy <= 1'b0;
            end
            // Sweep done, nothing is cached any more
            if (flush_ack) begin
                model_valid <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_rdata: assert property (@(posedge aclk) disable iff (rst)
        ctrl_rvalid && ctrl_rready |-> ctrl_rdata == exp_word)
        else begin
            mismatch_errs++;
            $display("mismatch ctrl_rdata: got %h, expected %h",
                     $sampled(ctrl_rdata), $sampled(exp_word));
        end

    // One AR per miss, none per hit
    a_ar_count: assert property (@(posedge aclk) disable iff (rst)
        ctrl_rvalid && ctrl_rready |-> ar_count == (exp_miss ? 1 : 0))
        else begin
            mismatch_errs++;
            $display("mismatch ar_count for %h: got %h, expected %h",
                     $sampled(exp_addr), $sampled(ar_count), $sampled(exp_miss));
        end

    a_no_ar_on_hit: assert property (@(posedge aclk) disable iff (rst)
        mem_arvalid |-> busy && exp_miss)
        else begin
            protocol_errs++;
            $display("memory read issued without a pending miss");
        end

    a_araddr: assert property (@(posedge aclk) disable iff (rst)
        mem_arvalid && mem_arready |-> mem_araddr == {exp_addr[15:4], 4'h0})
        else begin
            mismatch_errs++;
            $display("mismatch mem_araddr: got %h, expected %h",
                     $sampled(mem_araddr), {$sampled(exp_addr[15:4]), 4'h0});
        end

    a_ar_fields: assert property (@(posedge aclk) disable iff (rst)
        mem_arvalid |-> mem_arlen == 8'h0 && mem_arsize == 3'h4 && mem_arburst == 2'h1)
        else begin
            mismatch_errs++;
            $display("mismatch mem_arlen/arsize/arburst: got %h/%h/%h, expected 00/4/1",
                     $sampled(mem_arlen), $sampled(mem_arsize), $sampled(mem_arburst));
        end

    // Read data only taken for a miss whose address already went out
    a_rready_miss: assert property (@(posedge aclk) disable iff (rst)
        mem_rready |-> busy && exp_miss && ar_count == 1)
        else begin
            protocol_errs++;
            $display("mem_rready high without a sent address for a pending miss");
        end

    a_flush_hold: assert property (@(posedge aclk) disable iff (rst)
        $past(flush_ack && flush_req) |-> flush_ack)
        else begin
            protocol_errs++;
            $display("flush_ack dropped while flush_req was still high");
        end

    a_flush_block: assert property (@(posedge aclk) disable iff (rst)
        flush_req && !flush_ack |-> !ctrl_arready)
        else begin
            protocol_errs++;
            $display("fetch port ready while a flush was running");
        end

    // Fetch side back-pressure and one fetch in flight
    a_rvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        $past(ctrl_rvalid && !ctrl_rready) |-> ctrl_rvalid)
        else begin
            protocol_errs++;
            $display("ctrl_rvalid dropped before the response was taken");
        end

    a_rdata_hold: assert property (@(posedge aclk) disable iff (rst)
        $past(ctrl_rvalid && !ctrl_rready) |-> $stable(ctrl_rdata))
        else begin
            mismatch_errs++;
            $display("mismatch ctrl_rdata under back-pressure: got %h, expected %h",
                     $sampled(ctrl_rdata), $past(ctrl_rdata));
        end

    a_one_in_flight: assert property (@(posedge aclk) disable iff (rst)
        ctrl_rvalid |-> !ctrl_arready)
        else begin
            protocol_errs++;
            $display("fetch port ready while a response was pending");
        end

    // Memory side back-pressure
    a_arvalid_hold: assert property (@(posedge aclk) disable iff (rst)
        $past(mem_arvalid && !mem_arready) |-> mem_arvalid)
        else begin
            protocol_errs++;
            $display("mem_arvalid dropped before the address was taken");
        end

    a_araddr_hold: assert property (@(posedge aclk) disable iff (rst)
        $past(mem_arvalid && !mem_arready) |-> $stable(mem_araddr))
        else begin
            mismatch_errs++;
            $display("mismatch mem_araddr under back-pressure: got %h, expected %h",
                     $sampled(mem_araddr), $past(mem_araddr));
        end

    a_reset_idle: assert property (@(posedge aclk)
        $past(rst) && !rst |-> !ctrl_rvalid && !mem_arvalid && !flush_ack)
        else begin
            protocol_errs++;
            $display("outputs not idle after reset");
        end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic fetch_word(input addr_t addr);
        logic [31:0] r;
        ctrl_arvalid <= 1'b1;
        ctrl_araddr  <= addr;
        @(posedge aclk);
        while (!ctrl_arready) @(posedge aclk);
        ctrl_arvalid <= 1'b0;
        // Random ready stalls the data channel now and then
        r = $random(seed);
        ctrl_rready <= r[0] | r[1];
        @(posedge aclk);
        while (!(ctrl_rvalid && ctrl_rready)) begin
            r = $random(seed);
            ctrl_rready <= r[0] | r[1];
            @(posedge aclk);
        end
        ctrl_rready <= 1'b0;
    endtask

    // Four-phase handshake, ack held for a random while
    task automatic flush_cache();
        logic [31:0] r;
        r = $random(seed);
        flush_req <= 1'b1;
        @(posedge aclk);
        while (!flush_ack) @(posedge aclk);
        repeat (r[1:0]) @(posedge aclk);
        flush_req <= 1'b0;
        @(posedge aclk);
        while (flush_ack) @(posedge aclk);
    endtask

    initial begin
        rst          <= 1'b1;
        flush_req    <= 1'b0;
        ctrl_arvalid <= 1'b0;
        ctrl_araddr  <= '0;
        ctrl_rready  <= 1'b0;
        repeat (16) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);
        // Miss, hit in the same line, index conflict, back again
        fetch_word(16'h0104);
        fetch_word(16'h010c);
        fetch_word(16'h2104);
        fetch_word(16'h0100);
        flush_cache();
        fetch_word(16'h0108);
        // Random mix over 64 lines, 4 tags per index
        for (int n = 0; n < 300; n++) begin
            rnd = $random(seed);
            if (rnd[15:12] == 4'h0) begin
                flush_cache();
            end
            fetch_word({6'h0, rnd[9:2], 2'b00});
        end
        repeat (4) @(posedge aclk);
        $display("Errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
        if (mismatch_errs + protocol_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display("Errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: icache_tb_mem.sv
/* Testbench AXI4 read slave */

`timescale 1ns/100ps

module icache_tb_mem import icache_pkg::*; #(
    parameter logic [31:0] seed_init   = 32'h0,
    parameter logic [31:0] pattern_key = 32'h0
) (
    input  logic       aclk,
    input  logic       rst,
    input  logic       arvalid,
    output logic       arready,
    input  addr_t      araddr,
    output logic       rvalid,
    input  logic       rready,
    output line_t      rdata,
    output logic [1:0] rresp,
    output logic       rlast
);

    integer      seed = seed_init;
    logic [31:0] rnd;
    logic        pending;
    logic [1:0]  delay;
    addr_t       line_addr;

    // Each word is its own byte address XOR the key
    function automatic line_t make_line(input addr_t base);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = {16'h0, base + addr_t'(i * 4)} ^ pattern_key;
        end
        return l;
    endfunction

    // Single beat, always OKAY
    assign rresp = 2'b00;
    assign rlast = rvalid;

    always @(posedge aclk) begin
        rnd = $random(seed);
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            pending <= 1'b0;
            delay   <= 2'd0;
        end else begin
            // Address taken, data follows after 0 to 3 idle cycles
            if (arvalid && arready) begin
                arready   <= 1'b0;
                pending   <= 1'b1;
                delay     <= rnd[1:0];
                line_addr <= {araddr[15:4], 4'h0};
            end else if (!pending && !rvalid) begin
                arready <= rnd[2];
            end
            if (pending) begin
                if (delay == 2'd0) begin
                    rvalid  <= 1'b1;
                    rdata   <= make_line(line_addr);
                    pending <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: icache_tb_clk.sv
/* Testbench clock */

`timescale 1ns/100ps

module icache_tb_clk (
    output logic aclk
);

    // 100 ns period, starts low
    always begin
        aclk = 1'b0;
        #50;
        aclk = 1'b1;
        #50;
    end

endmodule

// File: icache_top.sv
/* Instruction cache top */

`timescale 1ns/100ps

module icache_top import icache_pkg::*; (
    input  logic       aclk,
    input  logic       rst,
    // FENCE.i flush
    input  logic       flush_req,
    output logic       flush_ack,
    // Instruction fetch port
    input  logic       ctrl_arvalid,
    output logic       ctrl_arready,
    input  addr_t      ctrl_araddr,
    output logic       ctrl_rvalid,
    input  logic       ctrl_rready,
    output word_t      ctrl_rdata,
    // AXI4 read port to central memory
    output logic       mem_arvalid,
    input  logic       mem_arready,
    output addr_t      mem_araddr,
    output logic [7:0] mem_arlen,
    output logic [2:0] mem_arsize,
    output logic [1:0] mem_arburst,
    input  logic       mem_rvalid,
    output logic       mem_rready,
    input  line_t      mem_rdata,
    input  logic [1:0] mem_rresp,
    input  logic       mem_rlast
);

    icache_fill_if fill_if ();

    // Arrays, hit check and fetch responses
    icache_lookup icache_lookup_i (
        .aclk         (aclk),
        .rst          (rst),
        .ctrl_arvalid (ctrl_arvalid),
        .ctrl_arready (ctrl_arready),
        .ctrl_araddr  (ctrl_araddr),
        .ctrl_rvalid  (ctrl_rvalid),
        .ctrl_rready  (ctrl_rready),
        .ctrl_rdata   (ctrl_rdata),
        .fill         (fill_if.lookup_mp)
    );

    // Refill over AXI4 and flush sweep
    icache_memctrl icache_memctrl_i (
        .aclk        (aclk),
        .rst         (rst),
        .flush_req   (flush_req),
        .flush_ack   (flush_ack),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_arlen   (mem_arlen),
        .mem_arsize  (mem_arsize),
        .mem_arburst (mem_arburst),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_rlast   (mem_rlast),
        .fill        (fill_if.memctrl_mp)
    );

endmodule

// File: icache_memctrl.sv
/* Instruction cache memory controller */

`timescale 1ns/100ps

`include "icache_defs.svh"

module icache_memctrl import icache_pkg::*; (
    input  logic              aclk,
    input  logic              rst,
    // FENCE.i flush, four-phase
    input  logic              flush_req,
    output logic              flush_ack,
    // AXI4 read to central memory
    output logic              mem_arvalid,
    input  logic              mem_arready,
    output addr_t             mem_araddr,
    output logic [7:0]        mem_arlen,
    output logic [2:0]        mem_arsize,
    output logic [1:0]        mem_arburst,
    input  logic              mem_rvalid,
    output logic              mem_rready,
    input  line_t             mem_rdata,
    // Single beat only, so RLAST comes with every beat and RRESP is not acted on
    input  logic [1:0]        mem_rresp,
    input  logic              mem_rlast,
    icache_fill_if.memctrl_mp fill
);

    memctrl_state_t state;
    addr_t          araddr_q;
    line_t          line_q;
    index_t         sweep_cnt;
    logic           wen_q;
    logic           ack_q;
    logic           start_refill;
    logic           rd_done;

    // Flush wins over a refill request arriving in the same cycle
    assign start_refill = (state == MC_IDLE) && !flush_req && fill.refill_req;
    assign rd_done      = (state == MC_DATA) && mem_rvalid;

    ////////////////////////////////////////////////////////////
    // AXI4 read channels
    ////////////////////////////////////////////////////////////

    assign mem_arlen   = 8'd0;
    assign mem_arsize  = 3'(`ICACHE_ARSIZE);
    assign mem_arburst = 2'(`ICACHE_ARBURST);
    assign mem_arvalid = (state == MC_ADDR);
    assign mem_araddr  = araddr_q;
    assign mem_rready  = (state == MC_DATA);

    // Line-aligned address and returned line
    always_ff @(posedge aclk) begin
        if (start_refill) begin
            araddr_q <= fill.refill_addr & ~addr_t'(`ICACHE_LINE_W/8 - 1);
        end
        if (rd_done) begin
            line_q <= mem_rdata;
        end
    end

    // Refill and sweep FSM
    always_ff @(posedge aclk) begin
        if (rst) begin
            state     <= MC_IDLE;
            sweep_cnt <= '0;
            wen_q     <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            // Line write lasts a single cycle
            wen_q <= rd_done;
            case (state)
                MC_IDLE: begin
                    if (flush_req) begin
                        state     <= MC_FLUSH;
                        sweep_cnt <= '0;
                    end else if (fill.refill_req) begin
                        state <= MC_ADDR;
                    end
                end
                MC_ADDR: begin
                    if (mem_arready) begin
                        state <= MC_DATA;
                    end
                end
                MC_DATA: begin
                    if (mem_rvalid) begin
                        state <= MC_ACK;
                    end
                end
                // Ack follows the line write, drops after the request does
                MC_ACK: begin
                    if (ack_q && !fill.refill_req) begin
                        ack_q <= 1'b0;
                        state <= MC_IDLE;
                    end else begin
                        ack_q <= 1'b1;
                    end
                end
                MC_FLUSH: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_t'(`ICACHE_DEPTH - 1)) begin
                        state <= MC_FLUSH_ACK;
                    end
                end
                MC_FLUSH_ACK: begin
                    if (!flush_req) begin
                        state <= MC_IDLE;
                    end
                end
                default: begin
                    state <= MC_IDLE;
                end
            endcase
        end
    end

    assign flush_ack = (state == MC_FLUSH_ACK);

    ////////////////////////////////////////////////////////////
    // Line writes toward lookup
    ////////////////////////////////////////////////////////////

    // Also covers the first flush_req cycle so no fetch slips in
    assign fill.sweeping = (state == MC_FLUSH) ||
                           (flush_req && (state == MC_IDLE || state == MC_FLUSH_ACK));

    assign fill.refill_ack = ack_q;
    assign fill.line_wen   = wen_q || (state == MC_FLUSH);
    assign fill.line_index = (state == MC_FLUSH) ? sweep_cnt :
                             araddr_q[`ICACHE_ADDR_W-`ICACHE_TAG_W-1 -: `ICACHE_INDEX_W];
    assign fill.line_tag   = araddr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign fill.line_valid = (state != MC_FLUSH);
    assign fill.line_data  = line_q;

endmodule

// File: icache_lookup.sv
/* Instruction cache line lookup */

`timescale 1ns/100ps

`include "icache_defs.svh"

module icache_lookup import icache_pkg::*; (
    input  logic             aclk,
    input  logic             rst,
    // Fetch address channel
    input  logic             ctrl_arvalid,
    output logic             ctrl_arready,
    input  addr_t            ctrl_araddr,
    // Fetch data channel
    output logic             ctrl_rvalid,
    input  logic             ctrl_rready,
    output word_t            ctrl_rdata,
    // Refill and line writes
    icache_fill_if.lookup_mp fill
);

    lookup_state_t            state;
    addr_t                    addr_q;
    logic [`ICACHE_DEPTH-1:0] valid_q;
    tag_t                     tag_q [`ICACHE_DEPTH];
    line_t                    data_q [`ICACHE_DEPTH];
    index_t                   req_index;
    tag_t                     req_tag;
    index_t                   cur_index;
    logic [1:0]               word_sel;
    line_t                    cur_line;
    logic                     hit;
    logic                     accept;

    ////////////////////////////////////////////////////////////
    // Line storage
    ////////////////////////////////////////////////////////////

    // Valid bits are cleared by reset and by the flush sweep
    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill.line_wen) begin
            valid_q[fill.line_index] <= fill.line_valid;
        end
    end

    // Tag and data only change on a refill
    // so a pending response keeps its word during a sweep
    always_ff @(posedge aclk) begin
        if (fill.line_wen && fill.line_valid) begin
            tag_q[fill.line_index]  <= fill.line_tag;
            data_q[fill.line_index] <= fill.line_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Tag compare on the incoming address
    ////////////////////////////////////////////////////////////

    assign req_index = ctrl_araddr[`ICACHE_ADDR_W-`ICACHE_TAG_W-1 -: `ICACHE_INDEX_W];
    assign req_tag   = ctrl_araddr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign hit       = valid_q[req_index] && (tag_q[req_index] == req_tag);

    // One fetch in flight, none while the cache is being flushed
    assign ctrl_arready = (state == LK_IDLE) && !fill.sweeping;
    assign accept       = ctrl_arvalid && ctrl_arready;

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= ctrl_araddr;
        end
    end

    // Lookup FSM
    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= LK_IDLE;
        end else begin
            case (state)
                LK_IDLE: begin
                    if (accept) begin
                        state <= hit ? LK_RESPOND : LK_MISS;
                    end
                end
                // Hold the request until the line is in place
                LK_MISS: begin
                    if (fill.refill_ack) begin
                        state <= LK_WAIT_DROP;
                    end
                end
                LK_WAIT_DROP: begin
                    if (!fill.refill_ack) begin
                        state <= LK_RESPOND;
                    end
                end
                LK_RESPOND: begin
                    if (ctrl_rready) begin
                        state <= LK_IDLE;
                    end
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    assign fill.refill_req  = (state == LK_MISS);
    assign fill.refill_addr = addr_q;

    ////////////////////////////////////////////////////////////
    // Response word select
    ////////////////////////////////////////////////////////////

    // Word offset sits just above the two byte bits
    assign cur_index = addr_q[`ICACHE_ADDR_W-`ICACHE_TAG_W-1 -: `ICACHE_INDEX_W];
    assign word_sel  = addr_q[3:2];
    assign cur_line  = data_q[cur_index];

    // Held address and line keep data stable under back-pressure
    assign ctrl_rvalid = (state == LK_RESPOND);
    assign ctrl_rdata  = cur_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

// File: icache_fill_if.sv
/* Lookup to memory controller link */

`timescale 1ns/100ps

interface icache_fill_if import icache_pkg::*; ();

    // Four-phase refill request from lookup
    logic   refill_req;
    addr_t  refill_addr;
    logic   refill_ack;

    // Line write port into the cache arrays
    logic   line_wen;
    index_t line_index;
    tag_t   line_tag;
    logic   line_valid;
    line_t  line_data;

    // High while a flush is pending or running
    logic   sweeping;

    modport lookup_mp (
        output refill_req, refill_addr,
        input  refill_ack, line_wen, line_index, line_tag, line_valid, line_data, sweeping
    );

    modport memctrl_mp (
        input  refill_req, refill_addr,
        output refill_ack, line_wen, line_index, line_tag, line_valid, line_data, sweeping
    );

endinterface

// File: icache_pkg.sv
/* Instruction cache types */

`include "icache_defs.svh"

package icache_pkg;

    // Widths carrying a meaning
    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]  word_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;

    // Fetch side lookup FSM
    typedef enum logic [1:0] {
        LK_IDLE, LK_RESPOND, LK_MISS, LK_WAIT_DROP
    } lookup_state_t;

    // Memory controller FSM, refill and flush sweep
    typedef enum logic [2:0] {
        MC_IDLE, MC_ADDR, MC_DATA, MC_ACK, MC_FLUSH, MC_FLUSH_ACK
    } memctrl_state_t;

endpackage

// File: icache_defs.svh
/* Instruction cache geometry */

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Fetch address width in bits
`define ICACHE_ADDR_W   16
// One RISC-V instruction
`define ICACHE_WORD_W   32
// Cache line, also the AXI4 data width
`define ICACHE_LINE_W   128

// Direct-mapped, 16 lines
`define ICACHE_DEPTH    16
`define ICACHE_INDEX_W  4
`define ICACHE_TAG_W    8

// AXI4 read address fields, fixed for one 16-byte beat
`define ICACHE_ARSIZE   4
// INCR burst type
`define ICACHE_ARBURST  1

`endif
